//--- rtl/minimig_pkg.sv
/*
 * shared definitions for the system glue
 * bus widths, config field widths, rtc window, reset hold and sample tick
 * register target and ctrl bit enums
 */

package minimig_pkg;

	// --------------------------------------------------------------------------
	// host bus
	localparam int WB_ADR_W = 5;	// word address
	localparam int WB_DAT_W = 16;

	// configuration field widths
	localparam int MEMCFG_W  = 7;
	localparam int CHIPCFG_W = 5;
	localparam int CPUCFG_W  = 4;

	// rtc window, one nibble per address
	localparam int RTC_W    = 64;
	localparam int RTC_BASE = 16;	// nibble 0 lives here

	// frames of hold after the last reset source clears
	localparam int RESET_HOLD_FRAMES = 2;

	// --------------------------------------------------------------------------
	// audio sample tick
	localparam int CLK_HZ    = 28_000_000;
	localparam int SAMPLE_HZ = 44_100;
	localparam int ACC_W     = 32;

	// decoded register targets
	typedef enum logic [2:0] {
		REG_NONE    = 3'd0,
		REG_MEMCFG  = 3'd1,	// addr 0
		REG_CHIPCFG = 3'd2,	// addr 1
		REG_CPUCFG  = 3'd3,	// addr 2
		REG_CTRL    = 3'd4,	// addr 3
		REG_STATUS  = 3'd5,	// addr 4, read only
		REG_RTC     = 3'd6	// addr 16..31, read only
	} reg_sel_e;

	// bit positions inside CTRL
	typedef enum logic [1:0] {
		CTRL_USRRST    = 2'd0,	// self clearing
		CTRL_CPURST    = 2'd1,
		CTRL_LED_DIM_N = 2'd2
	} ctrl_bit_e;

endpackage

//--- rtl/wb_reg_port.sv
/*
 * wishbone classic slave for the host register port
 * single cycle ack, address decode, write strobe, registered read data
 */

`timescale 1ns/1ps

module wb_reg_port
	import minimig_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	// host bus
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [WB_DAT_W-1:0] wb_dat_i,
	output logic                wb_ack_o,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	// register side
	output logic                wr_o,
	output reg_sel_e            sel_o,
	output logic [3:0]          rtc_idx_o,
	output logic [WB_DAT_W-1:0] wdat_o,
	input  logic [WB_DAT_W-1:0] rdat_i
);

	logic req;	// master has a cycle open
	logic start;	// request seen with no ack pending
	logic wr_q;

	assign req   = wb_cyc_i & wb_stb_i;
	assign start = req & ~wb_ack_o;

	// --------------------------------------------------------------------------
	// address decode, done here only
	always_comb begin
		sel_o     = REG_NONE;
		rtc_idx_o = 4'(wb_adr_i - WB_ADR_W'(RTC_BASE));	// nibble number
		if (wb_adr_i >= WB_ADR_W'(RTC_BASE)) begin
			sel_o = REG_RTC;
		end else begin
			case (wb_adr_i)
				WB_ADR_W'(0): sel_o = REG_MEMCFG;
				WB_ADR_W'(1): sel_o = REG_CHIPCFG;
				WB_ADR_W'(2): sel_o = REG_CPUCFG;
				WB_ADR_W'(3): sel_o = REG_CTRL;
				WB_ADR_W'(4): sel_o = REG_STATUS;
				default:      sel_o = REG_NONE;	// unmapped, acks and reads zero
			endcase
		end
	end

	// master holds data until ack, so pass it straight on
	assign wdat_o = wb_dat_i;

	// --------------------------------------------------------------------------
	// handshake, ack one cycle after the request is sampled
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack_o <= 1'b0;
			wr_q     <= 1'b0;
		end else begin
			wb_ack_o <= start;
			wr_q     <= start & wb_we_i;	// strobe lines up with ack
		end
	end

	// read data captured on the edge that raises ack
	always_ff @(posedge clk) begin
		if (start && !wb_we_i) begin
			wb_dat_o <= rdat_i;
		end
	end

	assign wr_o = wr_q;	// target still held by master during ack

endmodule

//--- rtl/config_regs.sv
/*
 * configuration registers: memory, chipset, cpu and control
 * status and rtc nibble read mux
 * registered feature flags derived from the config
 */

`timescale 1ns/1ps

module config_regs
	import minimig_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wr_i,
	input  reg_sel_e             sel_i,
	input  logic [3:0]           rtc_idx_i,
	input  logic [WB_DAT_W-1:0]  wdat_i,
	output logic [WB_DAT_W-1:0]  rdat_o,
	input  logic [RTC_W-1:0]     rtc_i,
	input  logic                 ovl_i,	// kickstart overlay
	input  logic                 sys_reset_i,
	output logic                 usrrst_o,
	output logic                 cpurst_o,
	output logic                 led_dim_n_o,
	output logic [CHIPCFG_W-1:0] chipset_cfg_o,
	output logic                 turbochipram_o,
	output logic                 turbokick_o,
	output logic                 aga_o,
	output logic [1:0]           slow_config_o,
	output logic [CPUCFG_W-1:0]  cpu_config_o
);

	logic [MEMCFG_W-1:0]  memcfg_q, memcfg_d;
	logic [CHIPCFG_W-1:0] chipcfg_q, chipcfg_d;
	logic [CPUCFG_W-1:0]  cpucfg_q, cpucfg_d;
	logic                 cpurst_q, led_dim_n_q, usrrst_q;
	logic                 ctrl_wr;

	assign ctrl_wr = wr_i && (sel_i == REG_CTRL);

	// --------------------------------------------------------------------------
	// next config, flags are taken from this so they land with the write
	always_comb begin
		memcfg_d  = memcfg_q;
		chipcfg_d = chipcfg_q;
		cpucfg_d  = cpucfg_q;
		if (wr_i) begin
			case (sel_i)
				REG_MEMCFG:  memcfg_d  = wdat_i[MEMCFG_W-1:0];
				REG_CHIPCFG: chipcfg_d = wdat_i[CHIPCFG_W-1:0];
				REG_CPUCFG:  cpucfg_d  = wdat_i[CPUCFG_W-1:0];
				default: ;	// ctrl below, status/rtc/unmapped dropped
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			memcfg_q       <= '0;
			chipcfg_q      <= '0;
			cpucfg_q       <= '0;
			cpurst_q       <= 1'b0;
			led_dim_n_q    <= 1'b0;
			usrrst_q       <= 1'b0;
			turbochipram_o <= 1'b0;
			turbokick_o    <= 1'b0;
			aga_o          <= 1'b0;
			slow_config_o  <= '0;
		end else begin
			memcfg_q  <= memcfg_d;
			chipcfg_q <= chipcfg_d;
			cpucfg_q  <= cpucfg_d;
			usrrst_q  <= ctrl_wr & wdat_i[CTRL_USRRST];	// one cycle pulse
			if (ctrl_wr) begin
				cpurst_q    <= wdat_i[CTRL_CPURST];
				led_dim_n_q <= wdat_i[CTRL_LED_DIM_N];
			end
			// fast chip needs no overlay, fast chip enabled and 2MB chip
			turbochipram_o <= ~ovl_i & cpucfg_d[2] & (&memcfg_d[1:0]);
			turbokick_o    <= ~ovl_i & cpucfg_d[3];	// fast kick
			aga_o          <= chipcfg_d[4];
			slow_config_o  <= memcfg_d[3:2];
		end
	end

	// --------------------------------------------------------------------------
	// read mux for the selected target
	always_comb begin
		rdat_o = '0;
		case (sel_i)
			REG_MEMCFG:  rdat_o[MEMCFG_W-1:0]  = memcfg_q;
			REG_CHIPCFG: rdat_o[CHIPCFG_W-1:0] = chipcfg_q;
			REG_CPUCFG:  rdat_o[CPUCFG_W-1:0]  = cpucfg_q;
			REG_CTRL: begin
				rdat_o[CTRL_CPURST]    = cpurst_q;	// usrrst always reads 0
				rdat_o[CTRL_LED_DIM_N] = led_dim_n_q;
			end
			REG_STATUS:  rdat_o[0]   = sys_reset_i;
			REG_RTC:     rdat_o[3:0] = rtc_i[{rtc_idx_i, 2'b00} +: 4];
			default: ;
		endcase
	end

	assign usrrst_o      = usrrst_q;
	assign cpurst_o      = cpurst_q;
	assign led_dim_n_o   = led_dim_n_q;
	assign chipset_cfg_o = chipcfg_q;
	assign cpu_config_o  = cpucfg_q;

endmodule

//--- rtl/reset_sequencer.sv
/*
 * system reset sequencer
 * gathers reset sources, holds for a number of frames, cpu reset, ntsc latch
 */

`timescale 1ns/1ps

module reset_sequencer
	import minimig_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 rst_ext_i,	// from ctrl block
	input  logic                 kbd_reset_n_i,	// ctrl-amiga-amiga
	input  logic                 usrrst_i,
	input  logic                 cpurst_i,
	input  logic                 sof_i,	// start of frame
	input  logic [CHIPCFG_W-1:0] chipset_cfg_i,
	output logic                 sys_reset_o,
	output logic                 cpu_reset_n_o,
	output logic                 ntsc_o
);

	typedef logic [$clog2(RESET_HOLD_FRAMES + 1)-1:0] frame_cnt_t;

	logic       rst_src;	// any source still active
	logic       sys_reset_q;
	logic       ntsc_q;
	frame_cnt_t frame_cnt;

	assign rst_src = rst_ext_i | ~kbd_reset_n_i | usrrst_i;

	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			sys_reset_q <= 1'b1;
			frame_cnt   <= '0;
			ntsc_q      <= 1'b0;
		end else begin
			if (rst_src) begin
				sys_reset_q <= 1'b1;	// restart the hold
				frame_cnt   <= '0;
			end else if (sys_reset_q && sof_i) begin
				if (frame_cnt == frame_cnt_t'(RESET_HOLD_FRAMES - 1)) begin
					sys_reset_q <= 1'b0;	// last frame seen, release
					frame_cnt   <= '0;
				end else begin
					frame_cnt <= frame_cnt + 1'b1;
				end
			end
			// video mode only changes while in reset
			if (sys_reset_q) begin
				ntsc_q <= chipset_cfg_i[1];
			end
		end
	end

	assign sys_reset_o   = sys_reset_q;
	assign cpu_reset_n_o = ~(sys_reset_q | cpurst_i);
	assign ntsc_o        = ntsc_q;

endmodule

//--- rtl/sync_outputs.sv
/*
 * front panel outputs
 * vsync toggle for the control mcu, dimmable power led
 */

`timescale 1ns/1ps

module sync_outputs
	import minimig_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic vsync_n_i,
	input  logic hblank_i,
	input  logic led_n_i,	// led off request from cia
	input  logic led_dim_n_i,
	output logic init_b_o,
	output logic pwr_led_o
);

	logic vsync_n_q;	// previous sample
	logic vsync_fall;
	logic init_b_q;
	logic led_on;
	logic pwr_led_q;

	assign vsync_fall = vsync_n_q & ~vsync_n_i;

	// --------------------------------------------------------------------------
	// vsync edge for the mcu, osd update sync
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_n_q <= 1'b1;	// idle high, no false edge out of reset
			init_b_q  <= 1'b0;
		end else begin
			vsync_n_q <= vsync_n_i;
			if (vsync_fall) begin
				init_b_q <= ~init_b_q;
			end
		end
	end

	// --------------------------------------------------------------------------
	// power led
	// dim mode lights the led during hblank even when it is off
	always_comb begin
		if (led_dim_n_i) begin
			led_on = ~led_n_i;
		end else begin
			led_on = ~(led_n_i & ~hblank_i);	// dark only outside blanking
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pwr_led_q <= 1'b0;
		end else begin
			pwr_led_q <= led_on;
		end
	end

	assign init_b_o  = init_b_q;
	assign pwr_led_o = pwr_led_q;

endmodule

//--- rtl/sample_tick_gen.sv
/*
 * 44.1 kHz sample tick from the system clock by a fractional accumulator
 */

`timescale 1ns/1ps

module sample_tick_gen
	import minimig_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic cen_44100_o
);

	logic [ACC_W-1:0] acc_q;
	logic [ACC_W-1:0] acc_sum;	// accumulator plus one step

	assign acc_sum = acc_q + ACC_W'(SAMPLE_HZ);

	always_ff @(posedge clk) begin
		if (reset) begin
			acc_q       <= '0;
			cen_44100_o <= 1'b0;
		end else if (acc_sum >= ACC_W'(CLK_HZ)) begin
			acc_q       <= acc_sum - ACC_W'(CLK_HZ);	// keep remainder
			cen_44100_o <= 1'b1;
		end else begin
			acc_q       <= acc_sum;
			cen_44100_o <= 1'b0;
		end
	end

endmodule

//--- rtl/minimig_sys.sv
/*
 * system glue top level
 * host register port, config and flags, reset sequencer, panel outputs, sample tick
 */

`timescale 1ns/1ps

module minimig_sys
	import minimig_pkg::*;
(
	input  logic                clk,
	input  logic                reset,
	// host register port
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  logic [WB_ADR_W-1:0] wb_adr_i,
	input  logic [WB_DAT_W-1:0] wb_dat_i,
	output logic                wb_ack_o,
	output logic [WB_DAT_W-1:0] wb_dat_o,
	// system inputs
	input  logic [RTC_W-1:0]    rtc_i,
	input  logic                ovl_i,
	input  logic                rst_ext_i,
	input  logic                kbd_reset_n_i,
	input  logic                sof_i,
	input  logic                vsync_n_i,
	input  logic                hblank_i,
	input  logic                led_n_i,
	// reset and mode
	output logic                rst_out_o,	// minimig reset status
	output logic                cpu_reset_n_o,
	output logic                ntsc_o,
	// feature flags
	output logic                turbochipram_o,
	output logic                turbokick_o,
	output logic                aga_o,
	output logic [1:0]          slow_config_o,
	output logic [CPUCFG_W-1:0] cpu_config_o,
	// panel and timing
	output logic                init_b_o,
	output logic                pwr_led_o,
	output logic                cen_44100_o
);

	// --------------------------------------------------------------------------
	logic                 wr;
	reg_sel_e             sel;
	logic [3:0]           rtc_idx;
	logic [WB_DAT_W-1:0]  wdat;
	logic [WB_DAT_W-1:0]  rdat;
	logic                 usrrst;
	logic                 cpurst;
	logic                 led_dim_n;
	logic [CHIPCFG_W-1:0] chipset_cfg;

	wb_reg_port u_wb_reg_port (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc_i  (wb_cyc_i),
		.wb_stb_i  (wb_stb_i),
		.wb_we_i   (wb_we_i),
		.wb_adr_i  (wb_adr_i),
		.wb_dat_i  (wb_dat_i),
		.wb_ack_o  (wb_ack_o),
		.wb_dat_o  (wb_dat_o),
		.wr_o      (wr),
		.sel_o     (sel),
		.rtc_idx_o (rtc_idx),
		.wdat_o    (wdat),
		.rdat_i    (rdat)
	);

	config_regs u_config_regs (
		.clk            (clk),
		.reset          (reset),
		.wr_i           (wr),
		.sel_i          (sel),
		.rtc_idx_i      (rtc_idx),
		.wdat_i         (wdat),
		.rdat_o         (rdat),
		.rtc_i          (rtc_i),
		.ovl_i          (ovl_i),
		.sys_reset_i    (rst_out_o),	// status readback
		.usrrst_o       (usrrst),
		.cpurst_o       (cpurst),
		.led_dim_n_o    (led_dim_n),
		.chipset_cfg_o  (chipset_cfg),
		.turbochipram_o (turbochipram_o),
		.turbokick_o    (turbokick_o),
		.aga_o          (aga_o),
		.slow_config_o  (slow_config_o),
		.cpu_config_o   (cpu_config_o)
	);

	reset_sequencer u_reset_sequencer (
		.clk           (clk),
		.reset         (reset),
		.rst_ext_i     (rst_ext_i),
		.kbd_reset_n_i (kbd_reset_n_i),
		.usrrst_i      (usrrst),
		.cpurst_i      (cpurst),
		.sof_i         (sof_i),
		.chipset_cfg_i (chipset_cfg),
		.sys_reset_o   (rst_out_o),
		.cpu_reset_n_o (cpu_reset_n_o),
		.ntsc_o        (ntsc_o)
	);

	// --------------------------------------------------------------------------
	sync_outputs u_sync_outputs (
		.clk         (clk),
		.reset       (reset),
		.vsync_n_i   (vsync_n_i),
		.hblank_i    (hblank_i),
		.led_n_i     (led_n_i),
		.led_dim_n_i (led_dim_n),
		.init_b_o    (init_b_o),
		.pwr_led_o   (pwr_led_o)
	);

	sample_tick_gen u_sample_tick_gen (
		.clk         (clk),
		.reset       (reset),
		.cen_44100_o (cen_44100_o)
	);

endmodule

//--- tests/minimig_sys_sva.sv
/*
 * concurrent checks, bound into the bus port and the reset sequencer
 * single cycle ack after a request, cpu reset held during system reset
 */

`timescale 1ns/1ps

module minimig_sys_sva (
	input logic clk,
	input logic reset,
	input logic req,	// cyc & stb
	input logic ack,
	input logic sys_reset,
	input logic cpu_reset_n
);

	// ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
		else $error("ack held longer than one cycle");

	// ack only answers a request sampled with no ack pending
	ack_after_req: assert property (@(posedge clk) disable iff (reset)
		ack |-> ($past(req) && !$past(ack)))
		else $error("ack without a preceding request");

	// cpu stays in reset with the system
	cpu_in_reset: assert property (@(posedge clk) disable iff (reset)
		sys_reset |-> !cpu_reset_n)
		else $error("cpu released during system reset");

endmodule

bind wb_reg_port minimig_sys_sva u_sva_wb (
	.clk(clk), .reset(reset), .req(wb_cyc_i & wb_stb_i), .ack(wb_ack_o),
	.sys_reset(1'b0), .cpu_reset_n(1'b0)
);

bind reset_sequencer minimig_sys_sva u_sva_rst (
	.clk(clk), .reset(reset), .req(1'b0), .ack(1'b0),
	.sys_reset(sys_reset_o), .cpu_reset_n(cpu_reset_n_o)
);

//--- tests/tb_minimig_sys.sv
/*
 * testbench for the system glue top level
 * file driven register and flag tests, rtc window, reset sequencing,
 * front panel outputs and sample tick count
 */

`timescale 1ns/1ps

module tb_minimig_sys
	import minimig_pkg::*;
();

	logic clk = 1'b0;
	logic reset;
	logic wb_cyc, wb_stb, wb_we;
	logic [WB_ADR_W-1:0] wb_adr;
	logic [WB_DAT_W-1:0] wb_dat_w;
	logic wb_ack;
	logic [WB_DAT_W-1:0] wb_dat_r;
	logic [RTC_W-1:0] rtc;
	logic ovl, rst_ext, kbd_reset_n, sof, vsync_n, hblank, led_n;
	logic rst_out, cpu_reset_n, ntsc, turbochipram, turbokick, aga;
	logic [1:0] slow_config;
	logic [CPUCFG_W-1:0] cpu_config;
	logic init_b, pwr_led, cen_44100;

	logic [31:0] lcg_state = 32'd43562;
	int errors = 0;
	int checks = 0;
	int bad_tests = 0;
	int tick_pulses = 0;
	int tick_cycles = 0;
	logic tick_done = 1'b0;

	always #10 clk = ~clk;	// 20 ns period

	minimig_sys UUT (
		.clk(clk), .reset(reset),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
		.wb_dat_i(wb_dat_w), .wb_ack_o(wb_ack), .wb_dat_o(wb_dat_r),
		.rtc_i(rtc), .ovl_i(ovl), .rst_ext_i(rst_ext), .kbd_reset_n_i(kbd_reset_n),
		.sof_i(sof), .vsync_n_i(vsync_n), .hblank_i(hblank), .led_n_i(led_n),
		.rst_out_o(rst_out), .cpu_reset_n_o(cpu_reset_n), .ntsc_o(ntsc),
		.turbochipram_o(turbochipram), .turbokick_o(turbokick), .aga_o(aga),
		.slow_config_o(slow_config), .cpu_config_o(cpu_config),
		.init_b_o(init_b), .pwr_led_o(pwr_led), .cen_44100_o(cen_44100)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ------------------------------------------------------------------------
	// compare tasks, one per result type
	task automatic check_dat(input logic [WB_DAT_W-1:0] got, exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s got %b expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic check_cpucfg(input logic [CPUCFG_W-1:0] got, exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t ns: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$finish;
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		if (errs != 0) bad_tests++;
		$display("test %0d %s: %s (%0d errors)", num, name, (errs == 0) ? "PASS" : "FAIL", errs);
	endtask

	// ------------------------------------------------------------------------
	// one bus access, returns read data from the ack cycle
	task automatic bus_xfer(input logic we, input int adr, input int dat,
			output logic [WB_DAT_W-1:0] rdata);
		int t;
		t = 0;
		@(posedge clk);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= WB_ADR_W'(adr);
		wb_dat_w <= WB_DAT_W'(dat);
		@(negedge clk);
		while (!wb_ack) begin
			if (t >= 20) abort_run("timeout while waiting for wishbone ack");
			t++;
			@(negedge clk);
		end
		rdata = wb_dat_r;
		@(posedge clk);	// write lands on this edge
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic bus_write(input int adr, input int dat);
		logic [WB_DAT_W-1:0] dummy;
		bus_xfer(1'b1, adr, dat, dummy);
	endtask

	// one sof pulse after an lcg picked gap
	task automatic pulse_sof();
		lcg_state = lcg_next(lcg_state);
		repeat (1 + int'(lcg_state[18:16])) @(posedge clk);
		sof <= 1'b1;
		@(posedge clk);
		sof <= 1'b0;
		@(negedge clk);
	endtask

	task automatic wait_rst_out(input logic level);
		int t;
		t = 0;
		@(negedge clk);
		while (rst_out !== level) begin
			if (t >= 50) abort_run("timeout while waiting for rst_out level");
			t++;
			@(negedge clk);
		end
	endtask

	// ------------------------------------------------------------------------
	// register and flag lines from the data file
	task automatic run_file(output int reg_errs, output int flag_errs);
		int fd, n, e0;
		int a, b, c, d, e, f, g, h;
		byte op;
		string line;
		logic [WB_DAT_W-1:0] rd;
		reg_errs = 0;
		flag_errs = 0;
		fd = $fopen("tests/minimig_sys_tests.dat", "r");
		if (fd == 0) abort_run("data file tests/minimig_sys_tests.dat could not be opened");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 3 || line[0] == "#") continue;
			n = $sscanf(line, "%c %h %h %h %h %h %h %h %h", op, a, b, c, d, e, f, g, h);
			e0 = errors;
			if (op == "W") begin
				bus_write(a, b);
			end else if (op == "R") begin
				bus_xfer(1'b0, a, 0, rd);
				check_dat(rd, WB_DAT_W'(b), $sformatf("read addr %0h", a));
				reg_errs += errors - e0;
			end else if (op == "F") begin
				bus_write(0, a);
				bus_write(1, b);
				bus_write(2, c);
				@(posedge clk);
				ovl <= d[0];
				@(posedge clk);	// flags register the new ovl
				@(negedge clk);
				check_flag(turbochipram, e[0], "turbochipram");
				check_flag(turbokick, f[0], "turbokick");
				check_flag(aga, g[0], "aga");
				check_flag(slow_config[1], h[1], "slow_config[1]");
				check_flag(slow_config[0], h[0], "slow_config[0]");
				check_cpucfg(cpu_config, CPUCFG_W'(c), "cpu_config");
				flag_errs += errors - e0;
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------------
	// sample tick counter over the first cycles after reset
	initial begin
		int t;
		t = 0;
		@(negedge clk);
		while (reset !== 1'b0) begin
			if (t >= 100) abort_run("timeout while waiting for reset release");
			t++;
			@(negedge clk);
		end
		repeat (20000) begin
			@(negedge clk);
			tick_cycles++;
			if (cen_44100) tick_pulses++;
		end
		tick_done = 1'b1;
	end

	initial begin
		int e0, reg_errs, flag_errs, t;
		logic [WB_DAT_W-1:0] rd;
		logic [63:0] exp_ticks;
		logic init_prev;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		rtc = '0;
		ovl = 1'b0;
		rst_ext = 1'b0;
		kbd_reset_n = 1'b1;
		sof = 1'b0;
		vsync_n = 1'b1;
		hblank = 1'b0;
		led_n = 1'b1;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		repeat (RESET_HOLD_FRAMES) pulse_sof();	// let the power-on hold run out
		wait_rst_out(1'b0);

		// tests 1 and 3 share the data file
		run_file(reg_errs, flag_errs);
		report_test(1, "register readback", reg_errs);

		// 2: rtc window, nibble n at RTC_BASE + n
		e0 = errors;
		@(posedge clk);
		lcg_state = lcg_next(lcg_state);
		rtc[31:0] <= lcg_state;
		lcg_state = lcg_next(lcg_state);
		rtc[63:32] <= lcg_state;
		@(posedge clk);
		for (int n = 0; n < 16; n++) begin
			bus_xfer(1'b0, RTC_BASE + n, 0, rd);
			check_dat(rd, WB_DAT_W'((rtc >> (4 * n)) & 64'hf), $sformatf("rtc nibble %0d", n));
		end
		report_test(2, "rtc window", errors - e0);
		report_test(3, "feature flags", flag_errs);

		// 4: usrrst hold, ntsc latch, cpu reset
		e0 = errors;
		repeat (RESET_HOLD_FRAMES) pulse_sof();	// end the hold left by the file
		wait_rst_out(1'b0);
		bus_write(1, 2);	// chipcfg ntsc bit
		bus_write(3, 1);	// usrrst pulse
		wait_rst_out(1'b1);
		for (int k = 1; k < RESET_HOLD_FRAMES; k++) begin
			pulse_sof();
			check_flag(rst_out, 1'b1, "rst_out before last frame");
		end
		check_flag(ntsc, 1'b1, "ntsc latched in reset");
		check_flag(cpu_reset_n, 1'b0, "cpu reset during system reset");
		pulse_sof();
		check_flag(rst_out, 1'b0, "rst_out after last frame");
		check_flag(cpu_reset_n, 1'b1, "cpu released");
		bus_write(1, 0);
		@(negedge clk);
		check_flag(ntsc, 1'b1, "ntsc held out of reset");
		bus_write(3, 2);	// cpurst
		@(negedge clk);
		check_flag(cpu_reset_n, 1'b0, "cpurst holds cpu");
		bus_write(3, 0);
		@(negedge clk);
		check_flag(cpu_reset_n, 1'b1, "cpurst cleared");
		report_test(4, "reset sequencing", errors - e0);

		// 5: vsync toggle, then both led modes
		e0 = errors;
		for (int k = 0; k < 3; k++) begin
			init_prev = init_b;
			@(posedge clk);
			vsync_n <= 1'b0;
			@(posedge clk);
			@(negedge clk);
			check_flag(init_b, ~init_prev, "init_b toggle on vsync fall");
			lcg_state = lcg_next(lcg_state);
			repeat (2 + int'(lcg_state[17:16])) @(posedge clk);
			@(negedge clk);
			check_flag(init_b, ~init_prev, "init_b steady while vsync low");
			@(posedge clk);
			vsync_n <= 1'b1;
			repeat (2) @(posedge clk);
			@(negedge clk);
			check_flag(init_b, ~init_prev, "init_b steady on vsync rise");
		end
		for (int m = 0; m < 2; m++) begin
			bus_write(3, (m == 0) ? 4 : 0);	// led_dim_n on, then off
			for (int i = 0; i < 4; i++) begin
				@(posedge clk);
				led_n  <= i[0];
				hblank <= i[1];
				@(posedge clk);
				@(negedge clk);
				check_flag(pwr_led, (m == 0) ? !i[0] : !(i[0] && !i[1]),
					$sformatf("pwr_led dim_n=%0d led_n=%0d hblank=%0d", 1 - m, i[0], i[1]));
			end
		end
		report_test(5, "front panel", errors - e0);

		// 6: tick count, expected from the rate ratio
		e0 = errors;
		t = 0;
		while (!tick_done) begin
			if (t >= 40000) abort_run("timeout while waiting for sample tick count");
			t++;
			@(negedge clk);
		end
		exp_ticks = (64'(tick_cycles) * 64'(SAMPLE_HZ)) / 64'(CLK_HZ);
		check_dat(WB_DAT_W'(tick_pulses), WB_DAT_W'(exp_ticks), "cen_44100 pulse count");
		report_test(6, "sample tick", errors - e0);

		$display("tests 6, tests with errors %0d, checks %0d, errors %0d",
			bad_tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- sim.f
rtl/minimig_pkg.sv
rtl/wb_reg_port.sv
rtl/config_regs.sv
rtl/reset_sequencer.sv
rtl/sync_outputs.sv
rtl/sample_tick_gen.sv
rtl/minimig_sys.sv
tests/minimig_sys_sva.sv
tests/tb_minimig_sys.sv

//--- Makefile
# Verilator build and run for the system glue testbench

VERILATOR ?= verilator
TOP       ?= tb_minimig_sys
RTL_TOP   ?= minimig_sys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/minimig_sys_tests.dat
# W adr data | R adr expected (hex)
# F memcfg chipcfg cpucfg ovl turbochip turbokick aga slowcfg
W 00 007f
R 00 007f
W 00 ffa5
R 00 0025
W 01 001f
R 01 001f
W 01 0013
R 01 0013
W 02 000f
R 02 000f
W 02 fff5
R 02 0005
W 05 1234
R 05 0000
W 0f abcd
R 0f 0000
W 14 ffff
R 00 0025
W 04 ffff
W 03 0007
R 03 0006
R 04 0001
W 03 0004
R 03 0004
F 03 00 4 0 1 0 0 0
F 03 00 4 1 0 0 0 0
F 0c 10 8 0 0 1 1 3
F 0c 10 8 1 0 0 1 3
F 0f 13 c 0 1 1 1 3
F 0f 13 c 1 0 0 1 3
F 07 0f 7 0 1 0 0 1
F 00 00 0 0 0 0 0 0
